// File: src.f
hdl/wbd_pkg.sv
hdl/wb_host.sv
hdl/wb_interconnect.sv
hdl/glbl_cfg.sv
hdl/digital_core.sv
test/tb_clk_gen.sv
test/tb_digital_core.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, decide by the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module tb_digital_core -Mdir obj_dir -o sim
./obj_dir/sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/tb_digital_core.sv
`timescale 1ns/100ps

module tb_digital_core;

    localparam logic [31:0] CHIP_ID = 32'h5946_0001;
    localparam logic [31:0] SEED    = 32'h58bfdac7;
    localparam int          TIMEOUT = 40;  // cycles per bus access

    logic               clk;
    logic               rst_n;
    logic               cyc, stb, we;
    logic [31:0]        adr, wdat, rdat;
    logic [3:0]         sel;
    logic               ack, err;
    wbd_pkg::glb_ctrl_t glb_ctrl;
    wbd_pkg::clk_skew_t clk_skew;
    wbd_pkg::pad_skew_t pad_skew;
    logic [2:0]         user_irq;
    logic               soft_irq;
    logic [31:0]        mhartid;

    int                 errors = 0;
    logic [31:0]        rng = SEED;
    logic [31:0]        m_clk1, m_clk2, m_hart;  // expected register contents
    logic [7:0]         m_bank;
    wbd_pkg::irq_reg_t  m_irq;

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    digital_core UUT (
        .wb_clk_i  (clk),
        .rst_n_i   (rst_n),
        .wbs_cyc_i (cyc),
        .wbs_stb_i (stb),
        .wbs_we_i  (we),
        .wbs_adr_i (adr),
        .wbs_dat_i (wdat),
        .wbs_sel_i (sel),
        .wbs_dat_o (rdat),
        .wbs_ack_o (ack),
        .wbs_err_o (err),
        .glb_ctrl_o(glb_ctrl),
        .clk_skew_o(clk_skew),
        .pad_skew_o(pad_skew),
        .user_irq_o(user_irq),
        .soft_irq_o(soft_irq),
        .mhartid_o (mhartid)
    );

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                r[i*8 +: 8] = nw[i*8 +: 8];  // enabled lane only
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] local_adr(input logic [1:0] idx);
        logic [31:0] a;
        a = '0;
        a[wbd_pkg::HOST_LOCAL_BIT] = 1'b1;  // bridge registers
        a[3:2] = idx;
        return a;
    endfunction

    function automatic logic [31:0] core_adr(input logic [1:0] idx);
        logic [31:0] a;
        a = '0;  // region comes from bank select
        a[3:2] = idx;
        return a;
    endfunction

    // skew fields, one nibble each, wi lowest
    function automatic wbd_pkg::clk_skew_t skew_of(input logic [31:0] v);
        wbd_pkg::clk_skew_t s;
        s.wi    = v[3:0];
        s.riscv = v[7:4];
        s.uart  = v[11:8];
        s.spi   = v[15:12];
        s.sdram = v[19:16];
        s.glbl  = v[23:20];
        s.wh    = v[27:24];
        return s;
    endfunction

    function automatic wbd_pkg::pad_skew_t pad_of(input logic [31:0] v);
        wbd_pkg::pad_skew_t p;
        p.sd_co = v[3:0];
        p.sd_ci = v[7:4];
        p.sp_co = v[11:8];
        return p;
    endfunction

    //----------------------------------------------------------------------
    // compare tasks
    //----------------------------------------------------------------------
    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s got 0x%08h exp 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_glb_ctrl(input wbd_pkg::glb_ctrl_t got, input wbd_pkg::glb_ctrl_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail glb_ctrl_o got 0x%02h exp 0x%02h", got, exp);
        end
    endtask

    task automatic check_clk_skew(input wbd_pkg::clk_skew_t got, input wbd_pkg::clk_skew_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail clk_skew_o got 0x%07h exp 0x%07h", got, exp);
        end
    endtask

    task automatic check_pad_skew(input wbd_pkg::pad_skew_t got, input wbd_pkg::pad_skew_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail pad_skew_o got 0x%03h exp 0x%03h", got, exp);
        end
    endtask

    task automatic check_irq(input wbd_pkg::irq_reg_t got, input wbd_pkg::irq_reg_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail soft_irq_o/user_irq_o got 0x%01h exp 0x%01h", got, exp);
        end
    endtask

    task automatic check_resp(input string what, input logic got_ack, input logic got_err,
                              input logic exp_err);
        if (exp_err && !(got_err && !got_ack)) begin
            errors++;
            $display("%s did not end with err", what);
        end else if (!exp_err && !(got_ack && !got_err)) begin
            errors++;
            $display("%s did not end with ack", what);
        end
    endtask

    //----------------------------------------------------------------------
    // host bus accesses
    //----------------------------------------------------------------------
    task automatic bus_cycle(input string what, input logic wr, input logic [31:0] a,
                             input logic [31:0] d, input logic [3:0] be,
                             output logic [31:0] q, output logic got_ack, output logic got_err);
        int n;
        n = 0;
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = wr;
        adr  = a;
        wdat = d;
        sel  = be;
        do begin
            @(negedge clk);  // response is registered, look between edges
            n++;
        end while (!ack && !err && n < TIMEOUT);
        got_ack = ack;
        got_err = err;
        q       = rdat;
        if (!ack && !err) begin
            errors++;
            $display("%s at address 0x%08h got neither ack nor err", what, a);
        end
        cyc = 1'b0;  // released in the response cycle
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input string what, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] be, output logic got_ack, output logic got_err);
        logic [31:0] q;
        bus_cycle(what, 1'b1, a, d, be, q, got_ack, got_err);
    endtask

    task automatic wb_read(input string what, input logic [31:0] a, output logic [31:0] q,
                           output logic got_ack, output logic got_err);
        bus_cycle(what, 1'b0, a, 32'h0, 4'hF, q, got_ack, got_err);
    endtask

    task automatic write_expect_ack(input string what, input logic [31:0] a,
                                    input logic [31:0] d, input logic [3:0] be);
        logic k_ack, k_err;
        wb_write(what, a, d, be, k_ack, k_err);
        check_resp(what, k_ack, k_err, 1'b0);
    endtask

    task automatic read_and_compare(input string what, input logic [31:0] a,
                                    input logic [31:0] exp);
        logic [31:0] q;
        logic        k_ack, k_err;
        wb_read(what, a, q, k_ack, k_err);
        check_resp(what, k_ack, k_err, 1'b0);
        check_word(what, q, exp);
    endtask

    //----------------------------------------------------------------------
    // directed tests
    //----------------------------------------------------------------------
    task automatic test_reset_state();
        int n;
        n = 0;
        while (!rst_n && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            errors++;
            $display("reset was never released");
        end
        check_glb_ctrl(glb_ctrl, '0);  // all blocks held in reset
        check_clk_skew(clk_skew, '0);
        check_pad_skew(pad_skew, '0);
        check_irq({soft_irq, user_irq}, '0);
        check_word("mhartid_o", mhartid, 32'h0);
        check_word("wbs_ack_o", {31'h0, ack}, 32'h0);
        check_word("wbs_err_o", {31'h0, err}, 32'h0);
    endtask

    task automatic test_local_regs();
        logic [31:0] d;
        logic [3:0]  be;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            d   = rng;
            be  = (i == 0) ? 4'hF : rng[7:4];  // full word first, then lanes
            write_expect_ack("clk_ctrl1 write", local_adr(wbd_pkg::HOST_REG_CLK_CTRL1), d, be);
            m_clk1 = merge_bytes(m_clk1, d, be);
            rng = xorshift(rng);
            d   = rng;
            write_expect_ack("clk_ctrl2 write", local_adr(wbd_pkg::HOST_REG_CLK_CTRL2), d, be);
            m_clk2 = merge_bytes(m_clk2, d, be);
            write_expect_ack("bank_sel write", local_adr(wbd_pkg::HOST_REG_BANK_SEL), d, be);
            if (be[0]) begin
                m_bank = d[7:0];
            end
            read_and_compare("clk_ctrl1", local_adr(wbd_pkg::HOST_REG_CLK_CTRL1), m_clk1);
            read_and_compare("clk_ctrl2", local_adr(wbd_pkg::HOST_REG_CLK_CTRL2), m_clk2);
            read_and_compare("bank_sel", local_adr(wbd_pkg::HOST_REG_BANK_SEL), {24'h0, m_bank});
            check_clk_skew(clk_skew, skew_of(m_clk1));
            check_pad_skew(pad_skew, pad_of(m_clk2));
        end
    endtask

    task automatic test_reset_gating();
        logic [31:0]        q;
        logic               k_ack, k_err;
        wbd_pkg::glb_ctrl_t exp;
        wb_read("read with interconnect in reset", core_adr(wbd_pkg::GLBL_REG_CHIP_ID),
                q, k_ack, k_err);
        check_resp("read with interconnect in reset", k_ack, k_err, 1'b1);
        exp = '0;
        for (int i = 0; i < 4; i++) begin
            exp[i] = 1'b1;  // release one block at a time
            write_expect_ack("glb_ctrl write", local_adr(wbd_pkg::HOST_REG_GLB_CTRL),
                             {24'h0, exp}, 4'h1);
            check_glb_ctrl(glb_ctrl, exp);
            read_and_compare("glb_ctrl", local_adr(wbd_pkg::HOST_REG_GLB_CTRL), {24'h0, exp});
        end
    endtask

    task automatic select_bank(input logic [3:0] region);
        m_bank = {region, 4'h0};  // region is core adr[31:28]
        write_expect_ack("bank_sel write", local_adr(wbd_pkg::HOST_REG_BANK_SEL),
                         {24'h0, m_bank}, 4'h1);
    endtask

    task automatic test_global_regs();
        select_bank(wbd_pkg::REGION_GLBL);
        read_and_compare("chip id", core_adr(wbd_pkg::GLBL_REG_CHIP_ID), CHIP_ID);
        rng = xorshift(rng);
        write_expect_ack("chip id write", core_adr(wbd_pkg::GLBL_REG_CHIP_ID), rng, 4'hF);
        read_and_compare("chip id after write", core_adr(wbd_pkg::GLBL_REG_CHIP_ID), CHIP_ID);
        rng    = xorshift(rng);
        m_hart = rng;
        write_expect_ack("mhartid write", core_adr(wbd_pkg::GLBL_REG_MHARTID), m_hart, 4'hF);
        rng = xorshift(rng);
        write_expect_ack("mhartid lane write", core_adr(wbd_pkg::GLBL_REG_MHARTID), rng, 4'h6);
        m_hart = merge_bytes(m_hart, rng, 4'h6);
        read_and_compare("mhartid", core_adr(wbd_pkg::GLBL_REG_MHARTID), m_hart);
        check_word("mhartid_o", mhartid, m_hart);
        rng   = xorshift(rng);
        m_irq = rng[3:0];  // upper bits are not stored
        write_expect_ack("irq write", core_adr(wbd_pkg::GLBL_REG_IRQ), rng, 4'h1);
        read_and_compare("irq", core_adr(wbd_pkg::GLBL_REG_IRQ), {28'h0, m_irq});
        check_irq({soft_irq, user_irq}, m_irq);
        read_and_compare("glbl index 3", core_adr(2'd3), 32'h0);
    endtask

    task automatic test_unmapped_regions();
        logic [31:0] q;
        logic        k_ack, k_err;
        logic [3:0]  region;
        for (int i = 0; i < 3; i++) begin
            region = (i == 0) ? wbd_pkg::REGION_SPIM :
                     (i == 1) ? wbd_pkg::REGION_SDRAM : wbd_pkg::REGION_UART;
            select_bank(region);
            wb_read("read of unmapped region", core_adr(wbd_pkg::GLBL_REG_MHARTID),
                    q, k_ack, k_err);
            check_resp("read of unmapped region", k_ack, k_err, 1'b1);
            check_word("unmapped read data", q, 32'h0);  // holes return zero
            rng = xorshift(rng);
            wb_write("write of unmapped region", core_adr(wbd_pkg::GLBL_REG_MHARTID), rng,
                     4'hF, k_ack, k_err);
            check_resp("write of unmapped region", k_ack, k_err, 1'b1);
            wb_write("irq write of unmapped region", core_adr(wbd_pkg::GLBL_REG_IRQ), ~rng,
                     4'hF, k_ack, k_err);
            check_resp("irq write of unmapped region", k_ack, k_err, 1'b1);
        end
        // global regs must not have seen any of it
        check_word("mhartid_o", mhartid, m_hart);
        check_irq({soft_irq, user_irq}, m_irq);
        select_bank(wbd_pkg::REGION_GLBL);
        read_and_compare("mhartid after holes", core_adr(wbd_pkg::GLBL_REG_MHARTID), m_hart);
        read_and_compare("irq after holes", core_adr(wbd_pkg::GLBL_REG_IRQ), {28'h0, m_irq});
    endtask

    initial begin
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        wdat   = '0;
        sel    = '0;
        m_clk1 = '0;
        m_clk2 = '0;
        m_hart = '0;
        m_bank = '0;
        m_irq  = '0;
        test_reset_state();
        test_local_regs();
        test_reset_gating();
        test_global_regs();
        test_unmapped_regions();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 20,  // ns
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // low over the first rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: hdl/digital_core.sv
`timescale 1ns/100ps

module digital_core #(
    parameter logic [31:0] CHIP_ID = 32'h5946_0001,
    parameter bit          STAGED  = 1'b1
) (
    input  logic                         wb_clk_i,   // system clock
    input  logic                         rst_n_i,    // sync, active low
    // host wishbone port
    input  logic                         wbs_cyc_i,
    input  logic                         wbs_stb_i,
    input  logic                         wbs_we_i,
    input  logic [wbd_pkg::WB_WIDTH-1:0] wbs_adr_i,
    input  logic [wbd_pkg::WB_WIDTH-1:0] wbs_dat_i,
    input  logic [wbd_pkg::WB_SEL_W-1:0] wbs_sel_i,
    output logic [wbd_pkg::WB_WIDTH-1:0] wbs_dat_o,
    output logic                         wbs_ack_o,
    output logic                         wbs_err_o,
    // config fields, consumers outside this core
    output wbd_pkg::glb_ctrl_t           glb_ctrl_o,
    output wbd_pkg::clk_skew_t           clk_skew_o,
    output wbd_pkg::pad_skew_t           pad_skew_o,
    output logic [2:0]                   user_irq_o,
    output logic                         soft_irq_o,
    output logic [31:0]                  mhartid_o
);

    wbd_pkg::wb_req_t host_req;  // bridge -> interconnect
    wbd_pkg::wb_rsp_t host_rsp;
    wbd_pkg::wb_req_t glbl_req;  // interconnect -> global regs
    wbd_pkg::wb_rsp_t glbl_rsp;
    logic             wbd_int_rst_n;

    // interconnect side held in reset until the host releases it
    assign wbd_int_rst_n = rst_n_i & glb_ctrl_o.wbd_int_rst_n;

    //----------------------------------------------------------------------
    // host bridge
    //----------------------------------------------------------------------
    wb_host u_wb_host (
        .clk_i      (wb_clk_i),
        .rst_n_i    (rst_n_i),
        .wbm_cyc_i  (wbs_cyc_i),
        .wbm_stb_i  (wbs_stb_i),
        .wbm_we_i   (wbs_we_i),
        .wbm_adr_i  (wbs_adr_i),
        .wbm_dat_i  (wbs_dat_i),
        .wbm_sel_i  (wbs_sel_i),
        .wbm_dat_o  (wbs_dat_o),
        .wbm_ack_o  (wbs_ack_o),
        .wbm_err_o  (wbs_err_o),
        .wbs_req_o  (host_req),
        .wbs_rsp_i  (host_rsp),
        .glb_ctrl_o (glb_ctrl_o),
        .clk_skew_o (clk_skew_o),
        .pad_skew_o (pad_skew_o)
    );

    wb_interconnect #(
        .STAGED (STAGED)
    ) u_intercon (
        .clk_i      (wb_clk_i),
        .rst_n_i    (wbd_int_rst_n),
        .m_req_i    (host_req),
        .m_rsp_o    (host_rsp),
        .glbl_req_o (glbl_req),
        .glbl_rsp_i (glbl_rsp)
    );

    // chip id, hart id, irq controls
    glbl_cfg #(
        .CHIP_ID (CHIP_ID)
    ) u_glbl_cfg (
        .clk_i      (wb_clk_i),
        .rst_n_i    (wbd_int_rst_n),
        .req_i      (glbl_req),
        .rsp_o      (glbl_rsp),
        .mhartid_o  (mhartid_o),
        .user_irq_o (user_irq_o),
        .soft_irq_o (soft_irq_o)
    );

endmodule

// File: hdl/glbl_cfg.sv
`timescale 1ns/100ps

module glbl_cfg #(
    parameter logic [31:0] CHIP_ID = 32'h0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // register bus
    input  wbd_pkg::wb_req_t req_i,
    output wbd_pkg::wb_rsp_t rsp_o,
    // risc config, consumers dropped
    output logic [31:0]      mhartid_o,
    output logic [2:0]       user_irq_o,
    output logic             soft_irq_o
);

    logic [31:0]       mhartid;   // hart id fuse
    wbd_pkg::irq_reg_t irq;
    logic              acc;       // access taken this cycle
    logic [1:0]        reg_idx;
    logic [31:0]       wmask;
    logic [31:0]       rdata;

    // stb is still high in the ack cycle, do not take it twice
    assign acc     = req_i.stb & ~rsp_o.ack;
    assign reg_idx = req_i.adr[3:2];
    assign wmask   = wbd_pkg::be_mask(req_i.sel);

    //----------------------------------------------------------------------
    // register write
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mhartid <= '0;
            irq     <= '0;
        end else if (acc && req_i.we) begin
            case (reg_idx)
                wbd_pkg::GLBL_REG_MHARTID:
                    mhartid <= (mhartid & ~wmask) | (req_i.dat & wmask);
                wbd_pkg::GLBL_REG_IRQ:
                    if (req_i.sel[0]) begin
                        irq <= req_i.dat[3:0];  // only defined bits kept
                    end
                default: ;  // chip id read only, write just acked
            endcase
        end
    end

    // read mux
    always_comb begin
        case (reg_idx)
            wbd_pkg::GLBL_REG_CHIP_ID: rdata = CHIP_ID;
            wbd_pkg::GLBL_REG_MHARTID: rdata = mhartid;
            wbd_pkg::GLBL_REG_IRQ:     rdata = {28'h0, irq};
            default:                   rdata = '0;
        endcase
    end

    //----------------------------------------------------------------------
    // one cycle registered ack
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_o.ack <= 1'b0;
            rsp_o.err <= 1'b0;
        end else begin
            rsp_o.ack <= acc;
            rsp_o.err <= 1'b0;  // every index answers
        end
        rsp_o.dat <= rdata;
    end

    assign mhartid_o  = mhartid;
    assign user_irq_o = irq.user_irq;
    assign soft_irq_o = irq.soft_irq;

    // master lets go of stb right after the ack
    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_o.ack |=> !req_i.stb);

endmodule

// File: hdl/wb_interconnect.sv
`timescale 1ns/100ps

module wb_interconnect #(
    parameter bit STAGED = 1'b1  // registered request and response stages
) (
    input  logic             clk_i,
    input  logic             rst_n_i,      // tied to the interconnect reset bit
    // master, host bridge
    input  wbd_pkg::wb_req_t m_req_i,
    output wbd_pkg::wb_rsp_t m_rsp_o,
    // slave, global config block
    output wbd_pkg::wb_req_t glbl_req_o,
    input  wbd_pkg::wb_rsp_t glbl_rsp_i
);

    wbd_pkg::wb_req_t s_req;     // request on the slave side
    wbd_pkg::wb_rsp_t s_rsp;     // response ahead of the response stage
    logic [3:0]       region;    // adr[31:28] of current transfer
    logic             glbl_sel;

    assign glbl_sel = (region == wbd_pkg::REGION_GLBL);

    //----------------------------------------------------------------------
    // slave decode
    //----------------------------------------------------------------------
    always_comb begin
        glbl_req_o     = s_req;
        glbl_req_o.stb = s_req.stb & glbl_sel;  // other slaves are gone
    end

    // spim, sdram, uart and unknown regions are holes, answer err
    always_comb begin
        if (glbl_sel) begin
            s_rsp = glbl_rsp_i;
        end else begin
            s_rsp.ack = 1'b0;
            s_rsp.err = s_req.stb;
            s_rsp.dat = '0;
        end
    end

    generate
        if (STAGED) begin : g_staged
            logic pend;  // master request accepted, response not yet given

            // request stage, region held for the whole transfer
            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    pend      <= 1'b0;
                    s_req.stb <= 1'b0;
                end else begin
                    if (m_req_i.stb && !pend) begin
                        pend   <= 1'b1;
                        s_req  <= m_req_i;
                        region <= m_req_i.adr[31:28];
                    end else if (s_rsp.ack || s_rsp.err) begin
                        s_req.stb <= 1'b0;
                    end
                    if (m_rsp_o.ack || m_rsp_o.err) begin
                        pend <= 1'b0;  // master drops stb now
                    end
                end
            end

            // response stage
            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    m_rsp_o.ack <= 1'b0;
                    m_rsp_o.err <= 1'b0;
                end else begin
                    m_rsp_o.ack <= s_rsp.ack;
                    m_rsp_o.err <= s_rsp.err;
                end
                m_rsp_o.dat <= s_rsp.dat;
            end

            a_rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                (m_rsp_o.ack || m_rsp_o.err) |-> pend);
        end else begin : g_comb
            // plain pass through, err comes back in the request cycle
            assign s_req   = m_req_i;
            assign region  = m_req_i.adr[31:28];
            assign m_rsp_o = s_rsp;
        end
    endgenerate

    // slave strobe only while the master still holds a global region address
    a_glbl_region: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        glbl_req_o.stb |-> m_req_i.stb && m_req_i.adr[31:28] == wbd_pkg::REGION_GLBL);

endmodule

// File: hdl/wb_host.sv
`timescale 1ns/100ps

module wb_host (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // host port
    input  logic                         wbm_cyc_i,
    input  logic                         wbm_stb_i,
    input  logic                         wbm_we_i,
    input  logic [wbd_pkg::WB_WIDTH-1:0] wbm_adr_i,
    input  logic [wbd_pkg::WB_WIDTH-1:0] wbm_dat_i,
    input  logic [wbd_pkg::WB_SEL_W-1:0] wbm_sel_i,
    output logic [wbd_pkg::WB_WIDTH-1:0] wbm_dat_o,
    output logic                         wbm_ack_o,
    output logic                         wbm_err_o,
    // toward interconnect
    output wbd_pkg::wb_req_t             wbs_req_o,
    input  wbd_pkg::wb_rsp_t             wbs_rsp_i,
    // chip control
    output wbd_pkg::glb_ctrl_t           glb_ctrl_o,
    output wbd_pkg::clk_skew_t           clk_skew_o,
    output wbd_pkg::pad_skew_t           pad_skew_o
);

    wbd_pkg::glb_ctrl_t          glb_ctrl;    // per block resets
    logic [wbd_pkg::WB_WIDTH-1:0] clk_ctrl1;
    logic [wbd_pkg::WB_WIDTH-1:0] clk_ctrl2;
    logic [7:0]                   bank_sel;    // core adr[31:24]

    logic                         acc;         // new access seen
    logic                         acc_local;
    logic                         acc_fwd;
    logic                         fwd_refuse;  // interconnect still in reset
    logic                         fwd_done;
    logic [1:0]                   reg_idx;
    logic [wbd_pkg::WB_WIDTH-1:0] wmask;
    logic [wbd_pkg::WB_WIDTH-1:0] local_rdata;

    // no new access while a response is out or a forward is in flight
    assign acc        = wbm_cyc_i & wbm_stb_i & ~wbm_ack_o & ~wbm_err_o & ~wbs_req_o.stb;
    assign acc_local  = acc & wbm_adr_i[wbd_pkg::HOST_LOCAL_BIT];
    assign acc_fwd    = acc & ~wbm_adr_i[wbd_pkg::HOST_LOCAL_BIT];
    assign fwd_refuse = acc_fwd & ~glb_ctrl.wbd_int_rst_n;
    assign fwd_done   = wbs_req_o.stb & (wbs_rsp_i.ack | wbs_rsp_i.err);
    assign reg_idx    = wbm_adr_i[3:2];
    assign wmask      = wbd_pkg::be_mask(wbm_sel_i);

    //----------------------------------------------------------------------
    // local control registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            glb_ctrl  <= '0;  // every block held in reset
            clk_ctrl1 <= '0;
            clk_ctrl2 <= '0;
            bank_sel  <= '0;
        end else if (acc_local && wbm_we_i) begin
            case (reg_idx)
                wbd_pkg::HOST_REG_GLB_CTRL:
                    glb_ctrl <= (glb_ctrl & ~wmask[7:0]) | (wbm_dat_i[7:0] & wmask[7:0]);
                wbd_pkg::HOST_REG_CLK_CTRL1:
                    clk_ctrl1 <= (clk_ctrl1 & ~wmask) | (wbm_dat_i & wmask);
                wbd_pkg::HOST_REG_CLK_CTRL2:
                    clk_ctrl2 <= (clk_ctrl2 & ~wmask) | (wbm_dat_i & wmask);
                default:
                    bank_sel <= (bank_sel & ~wmask[7:0]) | (wbm_dat_i[7:0] & wmask[7:0]);
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            wbd_pkg::HOST_REG_GLB_CTRL:  local_rdata = {24'h0, glb_ctrl};
            wbd_pkg::HOST_REG_CLK_CTRL1: local_rdata = clk_ctrl1;
            wbd_pkg::HOST_REG_CLK_CTRL2: local_rdata = clk_ctrl2;
            default:                     local_rdata = {24'h0, bank_sel};
        endcase
    end

    //----------------------------------------------------------------------
    // forwarded request, held until the core side answers
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wbs_req_o.stb <= 1'b0;
        end else if (acc_fwd && glb_ctrl.wbd_int_rst_n) begin
            wbs_req_o.stb <= 1'b1;
            wbs_req_o.we  <= wbm_we_i;
            wbs_req_o.adr <= {bank_sel, wbm_adr_i[23:0]};  // bank extended address
            wbs_req_o.dat <= wbm_dat_i;
            wbs_req_o.sel <= wbm_sel_i;
        end else if (fwd_done) begin
            wbs_req_o.stb <= 1'b0;  // low the cycle after the response
        end
    end

    // host response register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wbm_ack_o <= 1'b0;
            wbm_err_o <= 1'b0;
        end else begin
            wbm_ack_o <= acc_local | (fwd_done & wbs_rsp_i.ack);
            wbm_err_o <= fwd_refuse | (fwd_done & wbs_rsp_i.err);
        end
        if (acc_local) begin
            wbm_dat_o <= local_rdata;
        end else if (fwd_done) begin
            wbm_dat_o <= wbs_rsp_i.dat;
        end
    end

    assign glb_ctrl_o = glb_ctrl;
    assign clk_skew_o = clk_ctrl1[27:0];  // top nibble has no consumer
    assign pad_skew_o = clk_ctrl2[11:0];

    a_host_one_kind: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wbm_ack_o && wbm_err_o));

    // core side answers only a request that is still up
    a_fwd_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wbs_rsp_i.ack || wbs_rsp_i.err) |-> wbs_req_o.stb);

endmodule

// File: hdl/wbd_pkg.sv
package wbd_pkg;

    //----------------------------------------------------------------------
    // bus widths
    //----------------------------------------------------------------------
    localparam int WB_WIDTH = 32;            // address and data
    localparam int WB_SEL_W = WB_WIDTH / 8;  // one select per byte lane

    // request, stb stands for cyc and stb together
    typedef struct packed {
        logic                stb;
        logic                we;
        logic [WB_WIDTH-1:0] adr;
        logic [WB_WIDTH-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic                err;
        logic [WB_WIDTH-1:0] dat;
    } wb_rsp_t;

    //----------------------------------------------------------------------
    // chip control fields
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [3:0] rsvd;           // spare, stored and read back
        logic       sdram_rst_n;
        logic       spi_rst_n;
        logic       cpu_rst_n;
        logic       wbd_int_rst_n;  // interconnect + global regs
    } glb_ctrl_t;

    // clk_ctrl1, wi sits in the low nibble
    typedef struct packed {
        logic [3:0] wh;
        logic [3:0] glbl;
        logic [3:0] sdram;
        logic [3:0] spi;
        logic [3:0] uart;
        logic [3:0] riscv;
        logic [3:0] wi;
    } clk_skew_t;

    typedef struct packed {
        logic [3:0] sp_co;  // spi clock out
        logic [3:0] sd_ci;  // sdram clock in
        logic [3:0] sd_co;  // sdram clock out
    } pad_skew_t;

    typedef struct packed {
        logic       soft_irq;
        logic [2:0] user_irq;
    } irq_reg_t;

    //----------------------------------------------------------------------
    // register map
    //----------------------------------------------------------------------
    localparam logic [1:0] HOST_REG_GLB_CTRL  = 2'd0;  // host adr[3:2]
    localparam logic [1:0] HOST_REG_CLK_CTRL1 = 2'd1;
    localparam logic [1:0] HOST_REG_CLK_CTRL2 = 2'd2;
    localparam logic [1:0] HOST_REG_BANK_SEL  = 2'd3;
    localparam int         HOST_LOCAL_BIT     = 23;

    localparam logic [3:0] REGION_SPIM  = 4'd0;  // core adr[31:28]
    localparam logic [3:0] REGION_GLBL  = 4'd1;
    localparam logic [3:0] REGION_SDRAM = 4'd2;
    localparam logic [3:0] REGION_UART  = 4'd3;

    localparam logic [1:0] GLBL_REG_CHIP_ID = 2'd0;  // core adr[3:2]
    localparam logic [1:0] GLBL_REG_MHARTID = 2'd1;
    localparam logic [1:0] GLBL_REG_IRQ     = 2'd2;

    // byte selects widened to a bit mask
    function automatic logic [WB_WIDTH-1:0] be_mask(input logic [WB_SEL_W-1:0] sel);
        logic [WB_WIDTH-1:0] m;
        for (int i = 0; i < WB_SEL_W; i++) begin
            m[i*8 +: 8] = {8{sel[i]}};
        end
        return m;
    endfunction

endpackage
